// File: bbc_glue_pkg.sv
package bbc_glue_pkg;

	// address widths
	localparam int sdram_addr_w = 25;
	localparam int cpu_addr_w = 16;

	// rom load bases in sdram
	localparam logic [sdram_addr_w-1:0] rom_base_os = 25'h080000;
	localparam logic [sdram_addr_w-1:0] rom_base_other = 25'h068000;

	// download index that only carries cmos contents
	localparam logic [7:0] cmos_index = 8'hff;

	// where an access lands
	typedef enum logic [2:0] {
		REG_LOADER,
		REG_VIDEO,
		REG_MAIN_RAM,
		REG_FILING_RAM,
		REG_MOS_ROM,
		REG_MODELB_ROM,
		REG_MASTER_ROM,
		REG_SIDEWAYS_RAM
	} region_e;

	// one cpu or video access from the core
	typedef struct packed {
		logic [cpu_addr_w-1:0] adr;
		logic [7:0] romsel;
		logic acc_y;
		logic shadow_ram;
		logic shadow_vid;
		logic phi0;
		logic we;
		logic [7:0] dout;
	} cpu_bus_t;

	// download port of the io controller
	typedef struct packed {
		logic download;
		logic wr;
		logic [7:0] index;
		logic [sdram_addr_w-1:0] addr;
		logic [7:0] data;
	} ioctl_t;

	typedef struct packed {
		logic [sdram_addr_w-1:0] addr;
		logic we;
		logic [7:0] din;
	} sdram_req_t;

	typedef struct packed {
		logic [sdram_addr_w-1:0] addr;
		logic we;
		logic [7:0] data;
	} loader_wr_t;

endpackage

// File: bbc_glue_top.sv
`timescale 1ns/1ps

module bbc_glue_top #(
	parameter int unsigned remap_hold_cycles = 4095,
	parameter int unsigned autoboot_cycles = 32000000
) (
	input logic clk_48m,
	input logic reset,
	input logic mem_sync,
	input logic pll_ready,
	input logic sdram_ready,
	input logic osd_reset,
	input logic button_reset,
	input logic model,
	input logic rommap,
	input logic autoboot_en,
	input bbc_glue_pkg::cpu_bus_t cpu,
	input bbc_glue_pkg::ioctl_t ioctl,
	output bbc_glue_pkg::sdram_req_t sdram,
	output logic core_reset,
	output logic autoboot_shift
);
	import bbc_glue_pkg::*;

	loader_wr_t loader_wr;

	rom_loader u_rom_loader (
		.clk_48m (clk_48m),
		.reset (reset),
		.mem_sync (mem_sync),
		.ioctl (ioctl),
		.loader_wr (loader_wr)
	);

	reset_ctrl #(
		.remap_hold_cycles (remap_hold_cycles),
		.autoboot_cycles (autoboot_cycles)
	) u_reset_ctrl (
		.clk_48m (clk_48m),
		.reset (reset),
		.mem_sync (mem_sync),
		.pll_ready (pll_ready),
		.sdram_ready (sdram_ready),
		.osd_reset (osd_reset),
		.button_reset (button_reset),
		.download (ioctl.download),
		.model (model),
		.rommap (rommap),
		.autoboot_en (autoboot_en),
		.core_reset (core_reset),
		.autoboot_shift (autoboot_shift)
	);

	// loader wins the sdram port while a download runs
	mem_map u_mem_map (
		.clk_48m (clk_48m),
		.cpu (cpu),
		.loader_wr (loader_wr),
		.download (ioctl.download),
		.model (model),
		.rommap (rommap),
		.sdram (sdram)
	);

endmodule

// File: mem_map.sv
`timescale 1ns/1ps

module mem_map (
	input logic clk_48m,
	input bbc_glue_pkg::cpu_bus_t cpu,
	input bbc_glue_pkg::loader_wr_t loader_wr,
	input logic download,
	input logic model,
	input logic rommap,
	output bbc_glue_pkg::sdram_req_t sdram
);
	import bbc_glue_pkg::*;

	// sdram areas besides the os rom
	localparam logic [sdram_addr_w-1:0] filing_base = 25'h00a000;
	localparam logic [sdram_addr_w-1:0] modelb_base = 25'h090000;
	localparam logic [sdram_addr_w-1:0] master_base = 25'h0a0000;
	localparam logic [sdram_addr_w-1:0] swram_base = 25'h040000;

	logic cpu_ram;
	logic mos_rom;
	logic sideways;
	logic mos_ram;
	logic filing_ram;
	logic sideways_ram;
	logic rom_selected;
	logic ram_write;
	region_e region;

	assign cpu_ram = !cpu.adr[15];
	assign mos_rom = (cpu.adr[15:14] == 2'b11);
	assign sideways = (cpu.adr[15:14] == 2'b10);

	// master private ram at 8000-8fff
	assign mos_ram = sideways && (cpu.adr[13:12] == 2'b00) && cpu.romsel[7];
	assign filing_ram = (cpu.adr[15:13] == 3'b110) && cpu.acc_y;

	// banks 4-7 are ram
	assign sideways_ram = sideways && (cpu.romsel[3:2] == 2'b01);

	// which rom banks are populated depends on model and low/high mapping
	always_comb begin
		if (model) begin
			rom_selected = (cpu.romsel[3:2] == 2'b00) || cpu.romsel[3];
		end else if (rommap) begin
			rom_selected = (cpu.romsel[3:2] == 2'b00);
		end else begin
			rom_selected = (cpu.romsel[3:2] == 2'b11);
		end
	end

	// first match wins
	always_comb begin
		if (download) begin
			region = REG_LOADER;
		end else if (!cpu.phi0) begin
			region = REG_VIDEO;
		end else if (cpu_ram || mos_ram) begin
			region = REG_MAIN_RAM;
		end else if (filing_ram) begin
			region = REG_FILING_RAM;
		end else if (mos_rom) begin
			region = REG_MOS_ROM;
		end else if (sideways && rom_selected && !model) begin
			region = REG_MODELB_ROM;
		end else if (sideways && rom_selected && model) begin
			region = REG_MASTER_ROM;
		end else begin
			region = REG_SIDEWAYS_RAM;
		end
	end

	assign ram_write = cpu.we && (cpu_ram || mos_ram || filing_ram || sideways_ram);

	always_comb begin
		sdram.we = ram_write;
		sdram.din = cpu.dout;
		case (region)
			REG_LOADER: begin
				sdram.addr = loader_wr.addr;
				sdram.we = loader_wr.we;
				sdram.din = loader_wr.data;
			end
			REG_VIDEO: sdram.addr = sdram_addr_w'({cpu.shadow_vid, cpu.adr});
			REG_MAIN_RAM: sdram.addr = sdram_addr_w'({cpu.shadow_ram, cpu.adr});
			REG_FILING_RAM: sdram.addr = filing_base + cpu.adr[12:0];
			REG_MOS_ROM: sdram.addr = rom_base_os + {model, cpu.adr[13:0]};
			REG_MODELB_ROM: sdram.addr = modelb_base + {cpu.romsel[1:0], cpu.adr[13:0]};
			REG_MASTER_ROM: begin
				// 64k per group of four banks, 16k per bank
				sdram.addr = master_base + {cpu.romsel[3:2], 16'h0000} +
					{cpu.romsel[1:0], cpu.adr[13:0]};
			end
			default: sdram.addr = swram_base + {cpu.romsel[3:0], cpu.adr[13:0]};
		endcase
	end

	// rom images must stay intact whatever the cpu does
	a_no_rom_write: assert property (@(posedge clk_48m)
		(region inside {REG_MOS_ROM, REG_MODELB_ROM, REG_MASTER_ROM}) |-> !sdram.we);

endmodule

// File: reset_ctrl.sv
`timescale 1ns/1ps

module reset_ctrl #(
	parameter int unsigned remap_hold_cycles = 4095,
	parameter int unsigned autoboot_cycles = 32000000
) (
	input logic clk_48m,
	input logic reset,
	input logic mem_sync,
	input logic pll_ready,
	input logic sdram_ready,
	input logic osd_reset,
	input logic button_reset,
	input logic download,
	input logic model,
	input logic rommap,
	input logic autoboot_en,
	output logic core_reset,
	output logic autoboot_shift
);

	localparam int remap_w = $clog2(remap_hold_cycles + 1);
	localparam int boot_w = $clog2(autoboot_cycles + 1);

	logic last_model;
	logic last_rommap;
	logic [remap_w-1:0] remap_cnt;
	logic remap_hold;
	logic reset_in;
	logic [boot_w-1:0] boot_cnt;

	// previous settings, no reset so they follow the inputs
	always_ff @(posedge clk_48m) begin
		last_model <= model;
		last_rommap <= rommap;
	end

	// keep the core in reset for a while after a mapping change
	always_ff @(posedge clk_48m) begin
		if (reset) begin
			remap_cnt <= '0;
		end else if (last_model != model || last_rommap != rommap) begin
			remap_cnt <= remap_w'(remap_hold_cycles);
		end else if (remap_cnt != '0) begin
			remap_cnt <= remap_cnt - 1'b1;
		end
	end

	assign remap_hold = (remap_cnt != '0);

	assign reset_in = !pll_ready || !sdram_ready || osd_reset || button_reset ||
		download || remap_hold;

	// only sampled at the memory slot boundary
	always_ff @(posedge clk_48m) begin
		if (reset) begin
			core_reset <= 1'b1;
		end else if (mem_sync) begin
			core_reset <= reset_in;
		end
	end

	// shift held down for a fixed time once the core runs
	always_ff @(posedge clk_48m) begin
		if (reset || core_reset) begin
			boot_cnt <= boot_w'(autoboot_cycles);
		end else if (boot_cnt != '0) begin
			boot_cnt <= boot_cnt - 1'b1;
		end
	end

	assign autoboot_shift = autoboot_en && (boot_cnt != '0);

	a_reset_on_sync: assert property (@(posedge clk_48m) disable iff (reset)
		$changed(core_reset) |-> $past(mem_sync));

endmodule

// File: rom_loader.sv
`timescale 1ns/1ps

module rom_loader (
	input logic clk_48m,
	input logic reset,
	input logic mem_sync,
	input bbc_glue_pkg::ioctl_t ioctl,
	output bbc_glue_pkg::loader_wr_t loader_wr
);
	import bbc_glue_pkg::*;

	logic pending;
	logic wr_we;
	logic [sdram_addr_w-1:0] wr_addr;
	logic [7:0] wr_data;
	logic [sdram_addr_w-1:0] load_base;

	// os image goes to its own area, everything else below it
	assign load_base = (ioctl.index == 8'h00) ? rom_base_os : rom_base_other;

	// one pending byte, a second write before mem_sync merges in
	always_ff @(posedge clk_48m) begin
		if (reset) begin
			pending <= 1'b0;
			wr_we <= 1'b0;
		end else begin
			if (mem_sync) begin
				pending <= 1'b0;
				wr_we <= pending;
			end
			if (ioctl.wr && ioctl.download && ioctl.index != cmos_index) begin
				pending <= 1'b1;
			end
		end
	end

	// address and data taken at the slot that raises we
	always_ff @(posedge clk_48m) begin
		if (mem_sync && pending) begin
			wr_addr <= ioctl.addr + load_base;
			wr_data <= ioctl.data;
		end
	end

	assign loader_wr = '{addr: wr_addr, we: wr_we, data: wr_data};

	// a loader write only comes out of a running download
	a_we_in_download: assert property (@(posedge clk_48m) disable iff (reset)
		$rose(wr_we) |-> $past(ioctl.download));

endmodule

// File: tb.f
+incdir+.
bbc_glue_pkg.sv
rom_loader.sv
reset_ctrl.sv
mem_map.sv
bbc_glue_top.sv
tb_bbc_glue.sv

// File: tb_cases.svh
`ifndef TB_CASES_SVH
`define TB_CASES_SVH

// columns: region, model, rommap, adr, romsel, acc_y, shadow_ram, shadow_vid,
// phi0, cpu we, expected sdram addr, expected sdram we
task automatic load_cases;
	// video fetches while phi0 is low
	add_case(REG_VIDEO, 0, 0, 16'h3000, 8'h00, 0, 0, 1, 0, 0, 25'h013000, 0);
	add_case(REG_VIDEO, 1, 1, 16'h5800, 8'h00, 0, 1, 0, 0, 0, 25'h005800, 0);
	// main ram and the master private ram window
	add_case(REG_MAIN_RAM, 0, 0, 16'h1234, 8'h00, 0, 0, 1, 1, 1, 25'h001234, 1);
	add_case(REG_MAIN_RAM, 1, 1, 16'h7fff, 8'h00, 0, 1, 0, 1, 1, 25'h017fff, 1);
	add_case(REG_MAIN_RAM, 1, 0, 16'h8123, 8'h80, 0, 0, 0, 1, 1, 25'h008123, 1);
	add_case(REG_MAIN_RAM, 0, 1, 16'h8fff, 8'h80, 0, 1, 0, 1, 1, 25'h018fff, 1);
	// filing system ram at c000-dfff
	add_case(REG_FILING_RAM, 1, 0, 16'hc456, 8'h00, 1, 0, 0, 1, 1, 25'h00a456, 1);
	add_case(REG_FILING_RAM, 0, 1, 16'hdfff, 8'h00, 1, 0, 0, 1, 0, 25'h00bfff, 0);
	// os rom, acc_y above dfff still reads rom
	add_case(REG_MOS_ROM, 0, 0, 16'hc123, 8'h00, 0, 0, 0, 1, 1, 25'h080123, 0);
	add_case(REG_MOS_ROM, 1, 1, 16'hffff, 8'h00, 0, 0, 0, 1, 1, 25'h087fff, 0);
	add_case(REG_MOS_ROM, 1, 0, 16'he000, 8'h00, 1, 0, 0, 1, 1, 25'h086000, 0);
	// model b sideways roms
	add_case(REG_MODELB_ROM, 0, 0, 16'h9abc, 8'h0e, 0, 0, 0, 1, 1, 25'h099abc, 0);
	add_case(REG_MODELB_ROM, 0, 1, 16'hb000, 8'h01, 0, 0, 0, 1, 1, 25'h097000, 0);
	// master sideways roms
	add_case(REG_MASTER_ROM, 1, 0, 16'h8000, 8'h00, 0, 0, 0, 1, 1, 25'h0a0000, 0);
	add_case(REG_MASTER_ROM, 1, 1, 16'ha5a5, 8'h0b, 0, 0, 0, 1, 1, 25'h0ce5a5, 0);
	add_case(REG_MASTER_ROM, 1, 0, 16'hbfff, 8'h0f, 0, 0, 0, 1, 1, 25'h0dffff, 0);
	add_case(REG_MASTER_ROM, 1, 1, 16'h9000, 8'h83, 0, 0, 0, 1, 1, 25'h0ad000, 0);
	// sideways ram, only banks 4-7 take writes
	add_case(REG_SIDEWAYS_RAM, 0, 0, 16'h8800, 8'h05, 0, 0, 0, 1, 1, 25'h054800, 1);
	add_case(REG_SIDEWAYS_RAM, 1, 1, 16'hb123, 8'h06, 0, 0, 0, 1, 1, 25'h05b123, 1);
	add_case(REG_SIDEWAYS_RAM, 0, 1, 16'h9000, 8'h0c, 0, 0, 0, 1, 1, 25'h071000, 0);
	add_case(REG_SIDEWAYS_RAM, 0, 0, 16'h8001, 8'h02, 0, 0, 0, 1, 1, 25'h048001, 0);
endtask

`endif

// File: tb_bbc_glue.sv
`timescale 1ns/1ps

module tb_bbc_glue;
	import bbc_glue_pkg::*;

	localparam int unsigned remap_hold = 20;
	localparam int unsigned boot_len = 50;
	localparam int wait_limit = 400;

	logic clk_48m = 1'b0;
	logic reset;
	logic mem_sync = 1'b0;
	logic pll_ready;
	logic sdram_ready;
	logic osd_reset;
	logic button_reset;
	logic model;
	logic rommap;
	logic autoboot_en;
	cpu_bus_t cpu;
	ioctl_t ioctl;
	sdram_req_t sdram;
	logic core_reset;
	logic autoboot_shift;

	logic [1:0] sync_cnt = 2'd0;
	logic last_sync = 1'b0;
	logic last_core_reset;
	int checks = 0;
	int mismatches = 0;
	int failures = 0;

	// table columns, one entry per row
	region_e case_region[$];
	logic case_model[$];
	logic case_rommap[$];
	cpu_bus_t case_cpu[$];
	logic [sdram_addr_w-1:0] case_addr[$];
	logic case_we[$];

	bbc_glue_top #(
		.remap_hold_cycles (remap_hold),
		.autoboot_cycles (boot_len)
	) u_bbc_glue_top (
		.clk_48m (clk_48m),
		.reset (reset),
		.mem_sync (mem_sync),
		.pll_ready (pll_ready),
		.sdram_ready (sdram_ready),
		.osd_reset (osd_reset),
		.button_reset (button_reset),
		.model (model),
		.rommap (rommap),
		.autoboot_en (autoboot_en),
		.cpu (cpu),
		.ioctl (ioctl),
		.sdram (sdram),
		.core_reset (core_reset),
		.autoboot_shift (autoboot_shift)
	);

	always #4 clk_48m = ~clk_48m;

	// one slot boundary every four clocks
	always @(posedge clk_48m) begin
		sync_cnt <= sync_cnt + 2'd1;
		mem_sync <= (sync_cnt == 2'd3);
	end

	// core_reset may only move in the cycle after a mem_sync
	always @(negedge clk_48m) begin
		if (!reset && core_reset !== last_core_reset && !last_sync) begin
			failures++;
			$display("core_reset changed at %0t without a mem_sync before it", $time);
		end
		last_sync <= mem_sync;
		last_core_reset <= core_reset;
	end

	task automatic add_case(input region_e region, input logic model_v, input logic rommap_v,
		input logic [15:0] adr, input logic [7:0] romsel, input logic acc_y,
		input logic shadow_ram, input logic shadow_vid, input logic phi0, input logic we,
		input logic [sdram_addr_w-1:0] exp_addr, input logic exp_we);
		cpu_bus_t c;
		c = '0;
		c.adr = adr;
		c.romsel = romsel;
		c.acc_y = acc_y;
		c.shadow_ram = shadow_ram;
		c.shadow_vid = shadow_vid;
		c.phi0 = phi0;
		c.we = we;
		case_region.push_back(region);
		case_model.push_back(model_v);
		case_rommap.push_back(rommap_v);
		case_cpu.push_back(c);
		case_addr.push_back(exp_addr);
		case_we.push_back(exp_we);
	endtask

	`include "tb_cases.svh"

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		mismatches++;
		$display("Mismatch %s: expected %0h, actual %0h", name, exp, act);
	endtask

	// returns on a falling edge once core_reset holds the level
	task automatic wait_core_reset(input logic level, input string why);
		int n;
		n = 0;
		@(negedge clk_48m);
		while (core_reset !== level && n < wait_limit) begin
			@(negedge clk_48m);
			n++;
		end
		if (core_reset !== level) begin
			failures++;
			$display("core_reset never reached %0b while waiting for %s", level, why);
		end
	endtask

	task automatic drive_source(input int src, input logic on);
		case (src)
			0: pll_ready <= !on;
			1: sdram_ready <= !on;
			2: osd_reset <= on;
			3: button_reset <= on;
			default: ioctl.download <= on;
		endcase
	endtask

	task automatic load_byte(input logic [7:0] index, input logic [sdram_addr_w-1:0] addr,
		input logic [sdram_addr_w-1:0] base, input logic expect_write);
		logic [7:0] data;
		int n;
		int high;
		string name;
		data = 8'($urandom);
		name = $sformatf("loader index %0h", index);
		@(posedge clk_48m);
		ioctl.download <= 1'b1;
		ioctl.wr <= 1'b1;
		ioctl.index <= index;
		ioctl.addr <= addr;
		ioctl.data <= data;
		@(posedge clk_48m);
		ioctl.wr <= 1'b0;
		n = 0;
		@(negedge clk_48m);
		while (sdram.we !== 1'b1 && n < 16) begin
			@(negedge clk_48m);
			n++;
		end
		checks++;
		if (!expect_write) begin
			if (sdram.we === 1'b1) begin
				failures++;
				$display("%s wrote to sdram although it carries cmos data", name);
			end
		end else if (sdram.we !== 1'b1) begin
			failures++;
			$display("%s never produced an sdram write", name);
		end else begin
			// the write shows one cycle after the first mem_sync past the ioctl strobe
			if (n < 1 || n > 4 || !last_sync) begin
				failures++;
				$display("%s did not start right after the next mem_sync (%0d cycles)",
					name, n);
			end
			if (sdram.addr !== sdram_addr_w'(addr + base)) begin
				report_mismatch({name, " addr"}, addr + base, sdram.addr);
			end
			if (sdram.din !== data) begin
				report_mismatch({name, " data"}, data, sdram.din);
			end
			high = 0;
			while (sdram.we === 1'b1 && high < wait_limit) begin
				high++;
				@(negedge clk_48m);
			end
			if (high != 4) begin
				report_mismatch({name, " we length"}, 4, high);
			end
		end
		@(posedge clk_48m);
		ioctl.download <= 1'b0;
	endtask

	task automatic check_autoboot(input logic enable);
		int n;
		int high;
		@(posedge clk_48m);
		autoboot_en <= enable;
		button_reset <= 1'b1;
		wait_core_reset(1'b1, "button before autoboot");
		@(posedge clk_48m);
		button_reset <= 1'b0;
		wait_core_reset(1'b0, "autoboot start");
		high = 0;
		while (autoboot_shift === 1'b1 && high < wait_limit) begin
			high++;
			@(negedge clk_48m);
		end
		checks++;
		if (high != (enable ? boot_len : 0)) begin
			report_mismatch($sformatf("autoboot en %0b length", enable),
				enable ? boot_len : 0, high);
		end
		// must not come back on its own
		for (n = 0; n < 20; n++) begin
			@(negedge clk_48m);
			if (autoboot_shift !== 1'b0) begin
				failures++;
				$display("autoboot_shift rose again after its window");
			end
		end
	endtask

	initial begin
		int seed;
		int n;
		logic seen_high;
		cpu_bus_t c;
		string name;
		string source_name [5];
		source_name = '{"pll", "sdram", "osd_reset", "button_reset", "download"};
		seed = $urandom(32'hc7a7);
		reset = 1'b1;
		pll_ready = 1'b1;
		sdram_ready = 1'b1;
		osd_reset = 1'b0;
		button_reset = 1'b0;
		model = 1'b0;
		rommap = 1'b0;
		autoboot_en = 1'b0;
		cpu = '0;
		cpu.phi0 = 1'b1;
		ioctl = '0;
		repeat (16) @(posedge clk_48m);
		reset <= 1'b0;

		// address map and write gating
		load_cases();
		for (int i = 0; i < case_region.size(); i++) begin
			@(posedge clk_48m);
			c = case_cpu[i];
			c.dout = 8'($urandom);
			model <= case_model[i];
			rommap <= case_rommap[i];
			cpu <= c;
			@(negedge clk_48m);
			checks++;
			name = $sformatf("row %0d %s", i, case_region[i].name());
			if (sdram.addr !== case_addr[i]) begin
				report_mismatch({name, " addr"}, case_addr[i], sdram.addr);
			end
			if (sdram.we !== case_we[i]) begin
				report_mismatch({name, " we"}, case_we[i], sdram.we);
			end
			if (sdram.din !== c.dout) begin
				report_mismatch({name, " din"}, c.dout, sdram.din);
			end
		end

		// rom downloads
		@(posedge clk_48m);
		cpu.we <= 1'b0;
		load_byte(8'h00, 25'h000123, 25'h080000, 1'b1);
		load_byte(8'h05, 25'h003ffe, 25'h068000, 1'b1);
		load_byte(8'hff, 25'h000010, 25'h000000, 1'b0);

		// each reset source on its own
		for (int s = 0; s < 5; s++) begin
			wait_core_reset(1'b0, "idle core");
			@(posedge clk_48m);
			drive_source(s, 1'b1);
			checks++;
			wait_core_reset(1'b1, source_name[s]);
			@(posedge clk_48m);
			drive_source(s, 1'b0);
		end

		// mapping change holds the core in reset
		wait_core_reset(1'b0, "remap start");
		@(posedge clk_48m);
		model <= !model;
		n = 0;
		seen_high = 1'b0;
		do begin
			@(negedge clk_48m);
			n++;
			if (core_reset === 1'b1) begin
				seen_high = 1'b1;
			end
		end while (!(seen_high && core_reset === 1'b0) && n < wait_limit);
		checks++;
		// change seen, counter loaded, hold runs out, then the next slot boundary
		if (!seen_high || core_reset !== 1'b0) begin
			failures++;
			$display("model change did not pulse core_reset");
		end else if (n < remap_hold + 3 || n > remap_hold + 6) begin
			failures++;
			$display("core_reset released after %0d cycles, expected %0d to %0d",
				n, remap_hold + 3, remap_hold + 6);
		end

		check_autoboot(1'b1);
		check_autoboot(1'b0);

		$display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule
